// File: verilog/credit_pkg.sv
// shared sizes for the credit link
// sender, link retiming and receiver FIFO all size their registers from here
// fifo_depth must stay a power of two, since the pointers use a wrap bit

package credit_pkg;

  // --------------------------------------------------
  // payload
  // --------------------------------------------------

  // bits per link word
  localparam int data_width = 8;

  // --------------------------------------------------
  // receiver buffer and credits
  // --------------------------------------------------

  // FIFO entries, also the total number of credits in the system
  localparam int fifo_depth = 16;

  // address bits of the FIFO
  localparam int ptr_width = $clog2(fifo_depth);

  // counters hold 0 .. fifo_depth inclusive
  localparam int cnt_width = ptr_width + 1;

  // --------------------------------------------------
  // link
  // --------------------------------------------------

  // register stages per direction
  localparam int link_stages = 3;

endpackage

// File: verilog/sd2vc.sv
// credit sender
// takes words from the producer on srdy/drdy and forwards each one as a
// single-cycle valid pulse, spending one credit per word
// credits return from the receiver as cr pulses over the link
`timescale 1ns/1ps

module sd2vc
  (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            in_srdy,
  output logic                            in_drdy,
  input  logic [credit_pkg::data_width-1:0] in_data,
  output logic                            s_vld,
  output logic [credit_pkg::data_width-1:0] s_data,
  input  logic                            s_cr
  );

  logic [credit_pkg::cnt_width-1:0] credits;
  logic [credit_pkg::cnt_width-1:0] nxt_credits;
  logic                             accept;

  // producer may hand over a word whenever a credit is in hand
  assign in_drdy = (credits != '0);
  assign accept  = in_srdy & in_drdy;

  // spent and returned in the same cycle cancel out
  always_comb
  begin
    case ({s_cr, accept})
      2'b10:   nxt_credits = credits + 1'b1;
      2'b01:   nxt_credits = credits - 1'b1;
      default: nxt_credits = credits;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      credits <= '0;
      s_vld   <= 1'b0;
    end
    else
    begin
      credits <= nxt_credits;
      s_vld   <= accept;
    end
  end

  // payload only moves with an accepted word
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      s_data <= in_data;
    end
  end

  // --------------------------------------------------
  // checks
  // --------------------------------------------------

  // receiver never hands out more credits than it has FIFO entries;
  // an underflow would wrap to a large value and trip this as well
  a_credit_range: assert property (
    @(posedge clk) disable iff (reset)
    credits <= credit_pkg::fifo_depth
  )
  else
    $error("sd2vc: credit count %0d outside 0..%0d",
           credits, credit_pkg::fifo_depth);

endmodule

// File: verilog/link_pipe.sv
// retimed link between sender and receiver
// valid and data travel forward, credit pulses travel backward,
// each through link_stages registers with no back-pressure
`timescale 1ns/1ps

module link_pipe
  (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            s_vld,
  input  logic [credit_pkg::data_width-1:0] s_data,
  output logic                            r_vld,
  output logic [credit_pkg::data_width-1:0] r_data,
  input  logic                            r_cr,
  output logic                            s_cr
  );

  logic [credit_pkg::link_stages-1:0] vld_q;
  logic [credit_pkg::link_stages-1:0] cr_q;
  logic [credit_pkg::data_width-1:0]  data_q [credit_pkg::link_stages];

  // --------------------------------------------------
  // control chains, cleared by reset
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      vld_q <= '0;
      cr_q  <= '0;
    end
    else
    begin
      vld_q[0] <= s_vld;
      cr_q[0]  <= r_cr;
      for (int i = 1; i < credit_pkg::link_stages; i++)
      begin
        vld_q[i] <= vld_q[i-1];
        cr_q[i]  <= cr_q[i-1];
      end
    end
  end

  // --------------------------------------------------
  // data chain, follows the valid bits
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    data_q[0] <= s_data;
    for (int i = 1; i < credit_pkg::link_stages; i++)
    begin
      data_q[i] <= data_q[i-1];
    end
  end

  assign r_vld  = vld_q[credit_pkg::link_stages-1];
  assign r_data = data_q[credit_pkg::link_stages-1];
  assign s_cr   = cr_q[credit_pkg::link_stages-1];

endmodule

// File: verilog/vc2sd.sv
// credit receiver
// buffers valid/credit words in a FIFO sized to the credit pool and
// presents them to the consumer on srdy/drdy
// credits are issued one per cycle until usage plus outstanding credits
// fills the FIFO
`timescale 1ns/1ps

module vc2sd
  (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            r_vld,
  output logic                            r_cr,
  input  logic [credit_pkg::data_width-1:0] r_data,
  output logic                            out_srdy,
  input  logic                            out_drdy,
  output logic [credit_pkg::data_width-1:0] out_data
  );

  // pointers carry one extra wrap bit to tell full from empty
  logic [credit_pkg::ptr_width:0]   wrptr;
  logic [credit_pkg::ptr_width:0]   nxt_wrptr;
  logic [credit_pkg::ptr_width:0]   rdptr;
  logic [credit_pkg::ptr_width:0]   nxt_rdptr;
  logic [credit_pkg::cnt_width-1:0] usage;
  logic [credit_pkg::cnt_width-1:0] nxt_usage;
  logic [credit_pkg::cnt_width-1:0] cissued;
  logic [credit_pkg::cnt_width-1:0] nxt_cissued;
  logic [credit_pkg::cnt_width:0]   crtotal;
  logic                             full;
  logic                             wr_en;
  logic                             rd_fire;

  logic [credit_pkg::data_width-1:0] buffer [credit_pkg::fifo_depth];

  // --------------------------------------------------
  // write side and credit accounting
  // --------------------------------------------------

  // entries in use, credits outstanding, plus the one going out now
  assign crtotal = {1'b0, usage} + {1'b0, cissued} + {{credit_pkg::cnt_width{1'b0}}, r_cr};

  assign full = (wrptr[credit_pkg::ptr_width-1:0] == rdptr[credit_pkg::ptr_width-1:0]) &&
                (wrptr[credit_pkg::ptr_width] != rdptr[credit_pkg::ptr_width]);

  assign wr_en   = r_vld & ~full;
  assign rd_fire = out_srdy & out_drdy;

  always_comb
  begin
    nxt_wrptr = wrptr;
    if (wr_en)
    begin
      nxt_wrptr = wrptr + 1'b1;
    end

    // a credit goes out, a word comes back
    case ({r_cr, r_vld})
      2'b10:   nxt_cissued = cissued + 1'b1;
      2'b01:   nxt_cissued = cissued - 1'b1;
      default: nxt_cissued = cissued;
    endcase

    case ({wr_en, rd_fire})
      2'b10:   nxt_usage = usage + 1'b1;
      2'b01:   nxt_usage = usage - 1'b1;
      default: nxt_usage = usage;
    endcase
  end

  // --------------------------------------------------
  // read side
  // --------------------------------------------------
  always_comb
  begin
    nxt_rdptr = rdptr;
    if (rd_fire)
    begin
      nxt_rdptr = rdptr + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wrptr    <= '0;
      rdptr    <= '0;
      usage    <= '0;
      cissued  <= '0;
      r_cr     <= 1'b0;
      out_srdy <= 1'b0;
    end
    else
    begin
      wrptr    <= nxt_wrptr;
      rdptr    <= nxt_rdptr;
      usage    <= nxt_usage;
      cissued  <= nxt_cissued;
      r_cr     <= (crtotal < credit_pkg::fifo_depth);
      // word written this edge shows up one edge later
      out_srdy <= (wrptr != nxt_rdptr);
    end
  end

  // storage, no reset
  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      buffer[wrptr[credit_pkg::ptr_width-1:0]] <= r_data;
    end
  end

  assign out_data = buffer[rdptr[credit_pkg::ptr_width-1:0]];

  // --------------------------------------------------
  // checks
  // --------------------------------------------------

  // sender only transmits against a credit, so a full FIFO sees no word
  a_no_overrun: assert property (
    @(posedge clk) disable iff (reset) full |-> !r_vld
  )
  else
    $error("vc2sd: word arrived while FIFO full");

  a_stall_stable: assert property (
    @(posedge clk) disable iff (reset)
    (out_srdy && !out_drdy) |=> (out_srdy && $stable(out_data))
  )
  else
    $error("vc2sd: output changed while stalled");

  a_credit_pool: assert property (
    @(posedge clk) disable iff (reset)
    (usage + cissued) <= credit_pkg::fifo_depth
  )
  else
    $error("vc2sd: usage %0d plus credits %0d exceeds FIFO", usage, cissued);

endmodule

// File: verilog/credit_link_top.sv
// credit link top level
// producer words enter on in_srdy/in_drdy, cross the retimed
// valid/credit link and leave on out_srdy/out_drdy
`timescale 1ns/1ps

module credit_link_top
  (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            in_srdy,
  output logic                            in_drdy,
  input  logic [credit_pkg::data_width-1:0] in_data,
  output logic                            out_srdy,
  input  logic                            out_drdy,
  output logic [credit_pkg::data_width-1:0] out_data
  );

  // sender side of the link
  logic                              s_vld;
  logic [credit_pkg::data_width-1:0] s_data;
  logic                              s_cr;

  // receiver side of the link
  logic                              r_vld;
  logic [credit_pkg::data_width-1:0] r_data;
  logic                              r_cr;

  sd2vc sender_i (
    .clk     (clk),
    .reset   (reset),
    .in_srdy (in_srdy),
    .in_drdy (in_drdy),
    .in_data (in_data),
    .s_vld   (s_vld),
    .s_data  (s_data),
    .s_cr    (s_cr)
  );

  link_pipe link_i (
    .clk    (clk),
    .reset  (reset),
    .s_vld  (s_vld),
    .s_data (s_data),
    .r_vld  (r_vld),
    .r_data (r_data),
    .r_cr   (r_cr),
    .s_cr   (s_cr)
  );

  vc2sd receiver_i (
    .clk      (clk),
    .reset    (reset),
    .r_vld    (r_vld),
    .r_cr     (r_cr),
    .r_data   (r_data),
    .out_srdy (out_srdy),
    .out_drdy (out_drdy),
    .out_data (out_data)
  );

endmodule

// File: include/tb_helpers.svh
// testbench helpers for the credit link
// random bit source, expected data rule and the value checker
// included inside the testbench module after the package is compiled
`ifndef TB_HELPERS_SVH
`define TB_HELPERS_SVH

// galois lfsr with taps x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
  logic [31:0] nxt;
  nxt = state >> 1;
  if (state[0])
  begin
    nxt = nxt ^ 32'h8020_0003;
  end
  return nxt;
endfunction

// expected word for a sequence number
function automatic logic [credit_pkg::data_width-1:0] ref_data(
  input int unsigned index
);
  logic [31:0] mixed;
  mixed = (index * 32'd167) ^ (index >> 3) ^ 32'h0000_00a5;
  return mixed[credit_pkg::data_width-1:0];
endfunction

// compare a value with its expected value and stop at the first difference
task automatic check_value(
  input string       what,
  input logic [31:0] got,
  input logic [31:0] expected
);
  if (got !== expected)
  begin
    $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, expected);
    $display("Something failed");
    $fatal(1, "value check failed");
  end
endtask

`endif

// File: tb/tb_credit_link.sv
// testbench for the credit link top level
// drives words on in_srdy/in_drdy, checks order and data on out_srdy/out_drdy,
// then covers reset, credit limit, drain, random back-pressure and latency
`timescale 1ns/1ps

module tb_credit_link;

  localparam logic [31:0] seed = 32'd71810;
  localparam int clk_period     = 20;
  localparam int deliver_words  = 200;
  localparam int random_words   = 300;
  localparam int extra_words    = 8;
  localparam int total_words    = deliver_words + credit_pkg::fifo_depth + extra_words +
                                  random_words + 1;
  localparam int timeout_cycles = total_words * 4 + 2000;
  localparam int stall_limit    = 200;

  // consumer modes
  localparam int out_random = 0;
  localparam int out_high   = 1;
  localparam int out_low    = 2;

  logic                              clk      = 1'b0;
  logic                              reset    = 1'b1;
  logic                              in_srdy  = 1'b0;
  logic [credit_pkg::data_width-1:0] in_data  = '0;
  logic                              out_drdy = 1'b0;
  logic                              in_drdy;
  logic                              out_srdy;
  logic [credit_pkg::data_width-1:0] out_data;

  // test sequence controls
  int   in_target = 0;
  logic in_random = 1'b0;
  int   out_mode  = out_low;

  // monitor state
  int                                in_count   = 0;
  int                                out_count  = 0;
  logic                              in_fire    = 1'b0;
  logic                              stall_seen = 1'b0;
  logic [credit_pkg::data_width-1:0] stall_data = '0;

  logic [31:0] lfsr_state = seed;

  `include "tb_helpers.svh"

  credit_link_top dut_i (
    .clk      (clk),
    .reset    (reset),
    .in_srdy  (in_srdy),
    .in_drdy  (in_drdy),
    .in_data  (in_data),
    .out_srdy (out_srdy),
    .out_drdy (out_drdy),
    .out_data (out_data)
  );

  always #(clk_period / 2) clk = ~clk;

  task automatic next_random_bit(output logic bit_out);
    lfsr_state = lfsr_next(lfsr_state);
    bit_out = lfsr_state[0];
  endtask

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1, "run stopped on error");
  endtask

  // sequence steps sit 5 ns after the edge when driver and monitor are done
  task automatic wait_cycle();
    @(posedge clk);
    #5;
  endtask

  task automatic wait_delivered(input int target);
    while (out_count < target)
    begin
      wait_cycle();
    end
  endtask

  // --------------------------------------------------
  // driver 1 ns after the rising edge
  // --------------------------------------------------
  always @(posedge clk)
  begin
    logic go;
    #1;
    case (out_mode)
      out_high: out_drdy = 1'b1;
      out_low:  out_drdy = 1'b0;
      default:
      begin
        next_random_bit(go);
        out_drdy = go;
      end
    endcase
    // word taken on this edge
    if (in_fire)
    begin
      in_srdy = 1'b0;
    end
    if (!in_srdy && in_count < in_target)
    begin
      go = 1'b1;
      if (in_random)
      begin
        next_random_bit(go);
      end
      if (go)
      begin
        in_srdy = 1'b1;
        in_data = ref_data(in_count);
      end
    end
  end

  // --------------------------------------------------
  // monitor at the falling edge where everything is settled
  // --------------------------------------------------
  always @(negedge clk)
  begin
    if (reset)
    begin
      in_fire    = 1'b0;
      stall_seen = 1'b0;
    end
    else
    begin
      // a stalled word stays on the output unchanged
      if (stall_seen)
      begin
        check_value("out_srdy while stalled", out_srdy, 1'b1);
        check_value("out_data while stalled", out_data, stall_data);
      end
      // values here are the ones the next rising edge will see
      in_fire = in_srdy & in_drdy;
      if (in_fire)
      begin
        in_count++;
      end
      if (out_srdy && out_drdy)
      begin
        check_value($sformatf("word %0d", out_count), out_data, ref_data(out_count));
        out_count++;
      end
      stall_seen = out_srdy & ~out_drdy;
      stall_data = out_data;
    end
  end

  initial
  begin
    #(timeout_cycles * clk_period);
    $display("timeout: the test sequence did not finish in %0d cycles", timeout_cycles);
    $display("Something failed");
    $fatal(1, "watchdog expired");
  end

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial
  begin
    int start;
    int quiet;
    int n;
    int lat;
    @(posedge clk);
    @(negedge clk);
    check_value("in_drdy during reset", in_drdy, 1'b0);
    check_value("out_srdy during reset", out_srdy, 1'b0);
    @(posedge clk);
    #1;
    reset = 1'b0;
    #4;

    // first credit has to cross the link
    n = 0;
    while (in_drdy !== 1'b1)
    begin
      if (n == 2 * credit_pkg::link_stages + 4)
      begin
        stop_on_error("in_drdy did not rise after reset was released");
      end
      wait_cycle();
      n++;
    end

    // in-order delivery with random gaps
    out_mode  = out_high;
    in_random = 1'b1;
    in_target = in_count + deliver_words;
    wait_delivered(in_target);

    // credit limit with the output blocked
    out_mode  = out_low;
    in_random = 1'b0;
    start     = in_count;
    in_target = start + credit_pkg::fifo_depth + extra_words;
    quiet = 0;
    n     = 0;
    while (quiet < 4 * credit_pkg::link_stages)
    begin
      wait_cycle();
      n++;
      quiet = in_drdy ? 0 : quiet + 1;
      if (n > stall_limit)
      begin
        stop_on_error("sender kept accepting words with the output blocked");
      end
    end
    check_value("words accepted while blocked", in_count - start, credit_pkg::fifo_depth);

    // drain then let the pending words through
    out_mode = out_high;
    wait_delivered(in_target);

    // random back-pressure on both sides
    in_random = 1'b1;
    out_mode  = out_random;
    in_target = in_count + random_words;
    wait_delivered(in_target);

    // latency of a single word through an idle link
    out_mode  = out_high;
    in_random = 1'b0;
    repeat (2 * credit_pkg::link_stages + 4) wait_cycle();
    if (!in_drdy || out_srdy)
    begin
      stop_on_error("link was not idle before the latency test");
    end
    start     = in_count;
    in_target = start + 1;
    while (in_count == start)
    begin
      wait_cycle();
    end
    lat = 0;
    while (!out_srdy)
    begin
      wait_cycle();
      lat++;
      if (lat > 4 * credit_pkg::link_stages)
      begin
        stop_on_error("out_srdy never rose after the single word was sent");
      end
    end
    check_value("latency in cycles", lat, credit_pkg::link_stages + 2);
    wait_delivered(in_target);

    repeat (4) wait_cycle();
    if (out_count != in_count)
    begin
      check_value("words received", out_count, in_count);
    end
    else
    begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

// File: sim.f
+incdir+include
verilog/credit_pkg.sv
verilog/sd2vc.sv
verilog/link_pipe.sv
verilog/vc2sd.sv
verilog/credit_link_top.sv
tb/tb_credit_link.sv

// File: Makefile
# Verilator flow for the credit link
# make lint   static checks over the whole file list
# make sim    build and run, pass only when the pass line is printed
# make clean  remove build output

VERILATOR  ?= verilator
TOP        ?= tb_credit_link
FILELIST   ?= sim.f
OBJ_DIR    ?= obj_dir
PASS_MSG   ?= Everything OK
LINT_FLAGS ?= -Wall --timing --assert
VFLAGS     ?= --binary --timing --assert -Wno-fatal
EXTRA      ?=

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) $(EXTRA) --top-module $(TOP) -f $(FILELIST)

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell grep -v '^+' $(FILELIST)) include/tb_helpers.svh
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
sim: $(SIM_BIN)
	@out="$$($(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
